// File: hdl/nts_engine_pkg.sv
/*
 * Shared widths, register map, identity words and enums for the NTS
 * engine register file. Imported with a wildcard by every module.
 */
package nts_engine_pkg;

  // --------------------------------------------------
  // Bus and counter widths
  // --------------------------------------------------
  localparam int API_ADDR_WIDTH   = 12;
  localparam int API_DATA_WIDTH   = 32;
  localparam int LOCAL_ADDR_WIDTH = 8;   // Lower address bits
  localparam int BLOCK_WIDTH      = API_ADDR_WIDTH - LOCAL_ADDR_WIDTH;
  localparam int COUNTER_WIDTH    = 64;
  localparam int NUM_STAT         = 6;

  // --------------------------------------------------
  // Identity words
  // --------------------------------------------------
  localparam logic [API_DATA_WIDTH-1:0] CORE_NAME0   = 32'h4e_54_53_5f; // "NTS_"
  localparam logic [API_DATA_WIDTH-1:0] CORE_NAME1   = 32'h45_4e_47_4e; // "ENGN"
  localparam logic [API_DATA_WIDTH-1:0] CORE_VERSION = 32'h30_2e_30_31; // "0.01"
  localparam logic [API_DATA_WIDTH-1:0] DEBUG_NAME   = 32'h44_42_55_47; // "DBUG"
  localparam logic [API_DATA_WIDTH-1:0] CTRL_VALUE   = 32'h0000_0001;

  // --------------------------------------------------
  // Engine block map
  // --------------------------------------------------
  localparam logic [LOCAL_ADDR_WIDTH-1:0] ADDR_NAME0   = 8'h00;
  localparam logic [LOCAL_ADDR_WIDTH-1:0] ADDR_NAME1   = 8'h01;
  localparam logic [LOCAL_ADDR_WIDTH-1:0] ADDR_VERSION = 8'h02;
  localparam logic [LOCAL_ADDR_WIDTH-1:0] ADDR_CTRL    = 8'h08;

  // --------------------------------------------------
  // Debug block map
  // --------------------------------------------------
  // Counter addresses hold the upper word and the lower word follows at +1
  localparam logic [LOCAL_ADDR_WIDTH-1:0] ADDR_DEBUG_NTS_PROCESSED  = 8'h00;
  localparam logic [LOCAL_ADDR_WIDTH-1:0] ADDR_DEBUG_NTS_BAD_COOKIE = 8'h02;
  localparam logic [LOCAL_ADDR_WIDTH-1:0] ADDR_DEBUG_NTS_BAD_AUTH   = 8'h04;
  localparam logic [LOCAL_ADDR_WIDTH-1:0] ADDR_DEBUG_NTS_BAD_KEYID  = 8'h06;
  localparam logic [LOCAL_ADDR_WIDTH-1:0] ADDR_DEBUG_NAME           = 8'h08;
  localparam logic [LOCAL_ADDR_WIDTH-1:0] ADDR_DEBUG_SYSTICK32      = 8'h09;
  localparam logic [LOCAL_ADDR_WIDTH-1:0] ADDR_DEBUG_ERROR_CRYPTO   = 8'h20;
  localparam logic [LOCAL_ADDR_WIDTH-1:0] ADDR_DEBUG_ERROR_TXBUF    = 8'h22;

  // --------------------------------------------------
  // Enums
  // --------------------------------------------------
  // Upper address bits select the block
  typedef enum logic [BLOCK_WIDTH-1:0] {
    BLOCK_ENGINE = 4'h0,
    BLOCK_DEBUG  = 4'h1,
    BLOCK_NONE   = 4'hf   // Anything unmapped
  } api_block_e;

  typedef enum logic [1:0] {
    OP_IDLE  = 2'd0,
    OP_READ  = 2'd1,
    OP_WRITE = 2'd2
  } api_op_e;

  // Bit position in event and snapshot vectors
  typedef enum logic [2:0] {
    STAT_PROCESSED  = 3'd0,
    STAT_BAD_COOKIE = 3'd1,
    STAT_BAD_AUTH   = 3'd2,
    STAT_BAD_KEYID  = 3'd3,
    STAT_ERR_CRYPTO = 3'd4,
    STAT_ERR_TXBUF  = 3'd5
  } stat_event_e;

endpackage

// File: hdl/nts_api_decode.sv
/*
 * First stage of the register bus. Samples one chip-select access per
 * cycle and holds it as an operation, a target block and a local address.
 */
module nts_api_decode
  import nts_engine_pkg::*;
(
  input  logic                        i_clk,
  input  logic                        i_areset,
  input  logic                        i_api_cs,
  input  logic                        i_api_we,
  input  logic [API_ADDR_WIDTH-1:0]   i_api_address,
  output api_op_e                     o_op,
  output api_block_e                  o_block,
  output logic [LOCAL_ADDR_WIDTH-1:0] o_local_addr
);

  api_op_e    op_next;
  api_block_e block_next;

  // Classify the access
  always_comb
  begin
    if (!i_api_cs)
      op_next = OP_IDLE;
    else if (i_api_we)
      op_next = OP_WRITE;  // Accepted, never acted on
    else
      op_next = OP_READ;
  end

  // Upper address bits onto a block
  always_comb
  begin
    case (i_api_address[API_ADDR_WIDTH-1:LOCAL_ADDR_WIDTH])
      BLOCK_ENGINE: block_next = BLOCK_ENGINE;
      BLOCK_DEBUG:  block_next = BLOCK_DEBUG;
      default:      block_next = BLOCK_NONE;
    endcase
  end

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      o_op    <= OP_IDLE;
      o_block <= BLOCK_NONE;
    end
    else
    begin
      o_op    <= op_next;
      o_block <= block_next;
    end
  end

  // Local address follows the bus every cycle
  always_ff @(posedge i_clk)
  begin
    o_local_addr <= i_api_address[LOCAL_ADDR_WIDTH-1:0];
  end

endmodule

// File: hdl/nts_stat_counters.sv
/*
 * Statistics counters of the engine. Each event pulse bumps its 64-bit
 * counter; a snapshot pulse freezes the lower word for a later read.
 */
module nts_stat_counters
  import nts_engine_pkg::*;
(
  input  logic                                     i_clk,
  input  logic                                     i_areset,
  input  logic [NUM_STAT-1:0]                      i_stat_events,
  input  logic [NUM_STAT-1:0]                      i_snapshot,
  output logic [NUM_STAT-1:0][API_DATA_WIDTH-1:0]  o_counter_msw,
  output logic [NUM_STAT-1:0][API_DATA_WIDTH-1:0]  o_snapshot_lsw,
  output logic [API_DATA_WIDTH-1:0]                o_systick
);

  // --------------------------------------------------
  // State
  // --------------------------------------------------
  logic [NUM_STAT-1:0][COUNTER_WIDTH-1:0]  counter_reg;
  logic [NUM_STAT-1:0][API_DATA_WIDTH-1:0] snapshot_reg;
  logic [API_DATA_WIDTH-1:0]               systick_reg;

  // --------------------------------------------------
  // Counter and snapshot update
  // --------------------------------------------------
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      counter_reg  <= '0;
      snapshot_reg <= '0;
    end
    else
    begin
      for (int i = 0; i < NUM_STAT; i++)
      begin
        if (i_stat_events[i])
          counter_reg[i] <= counter_reg[i] + 1'b1;

        // Lower word as it stood before this edge so that it pairs
        // with the upper word read out at the same edge
        if (i_snapshot[i])
          snapshot_reg[i] <= counter_reg[i][API_DATA_WIDTH-1:0];
      end
    end
  end

  // Free running tick that starts at 1 after reset
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
      systick_reg <= API_DATA_WIDTH'(1);
    else
      systick_reg <= systick_reg + 1'b1;
  end

  // --------------------------------------------------
  // Outputs
  // --------------------------------------------------
  always_comb
  begin
    for (int i = 0; i < NUM_STAT; i++)
    begin
      o_counter_msw[i] = counter_reg[i][COUNTER_WIDTH-1:API_DATA_WIDTH];  // Upper half
    end
  end

  assign o_snapshot_lsw = snapshot_reg;
  assign o_systick      = systick_reg;

endmodule

// File: hdl/nts_api_readback.sv
/*
 * Read side of the register file. Picks the word for a decoded read,
 * asks the counters for a lower-word snapshot and registers the result.
 */
module nts_api_readback
  import nts_engine_pkg::*;
(
  input  logic                                    i_clk,
  input  logic                                    i_areset,
  input  api_op_e                                 i_op,
  input  api_block_e                              i_block,
  input  logic [LOCAL_ADDR_WIDTH-1:0]             i_local_addr,
  input  logic [NUM_STAT-1:0][API_DATA_WIDTH-1:0] i_counter_msw,
  input  logic [NUM_STAT-1:0][API_DATA_WIDTH-1:0] i_snapshot_lsw,
  input  logic [API_DATA_WIDTH-1:0]               i_systick,
  output logic [NUM_STAT-1:0]                     o_snapshot,
  output logic [API_DATA_WIDTH-1:0]               o_api_read_data,
  output logic                                    o_api_read_valid
);

  logic                        is_read;
  logic [LOCAL_ADDR_WIDTH-1:0] pair_addr;   // Address with the word bit cleared
  logic                        is_lsw;
  logic                        stat_hit;
  stat_event_e                 stat_sel;
  logic [API_DATA_WIDTH-1:0]   engine_word;
  logic [API_DATA_WIDTH-1:0]   read_word;

  assign is_read   = (i_op == OP_READ);
  assign pair_addr = {i_local_addr[LOCAL_ADDR_WIDTH-1:1], 1'b0};
  assign is_lsw    = i_local_addr[0];

  // --------------------------------------------------
  // Counter address lookup
  // --------------------------------------------------
  always_comb
  begin
    stat_hit = 1'b1;
    stat_sel = STAT_PROCESSED;
    case (pair_addr)
      ADDR_DEBUG_NTS_PROCESSED:  stat_sel = STAT_PROCESSED;
      ADDR_DEBUG_NTS_BAD_COOKIE: stat_sel = STAT_BAD_COOKIE;
      ADDR_DEBUG_NTS_BAD_AUTH:   stat_sel = STAT_BAD_AUTH;
      ADDR_DEBUG_NTS_BAD_KEYID:  stat_sel = STAT_BAD_KEYID;
      ADDR_DEBUG_ERROR_CRYPTO:   stat_sel = STAT_ERR_CRYPTO;
      ADDR_DEBUG_ERROR_TXBUF:    stat_sel = STAT_ERR_TXBUF;
      default:                   stat_hit = 1'b0;
    endcase
  end

  // Engine identity words
  always_comb
  begin
    case (i_local_addr)
      ADDR_NAME0:   engine_word = CORE_NAME0;
      ADDR_NAME1:   engine_word = CORE_NAME1;
      ADDR_VERSION: engine_word = CORE_VERSION;
      ADDR_CTRL:    engine_word = CTRL_VALUE;
      default:      engine_word = '0;
    endcase
  end

  // --------------------------------------------------
  // Read select
  // --------------------------------------------------
  always_comb
  begin
    read_word  = '0;
    o_snapshot = '0;
    if (is_read)
    begin
      case (i_block)
        BLOCK_ENGINE:
          read_word = engine_word;
        BLOCK_DEBUG:
        begin
          if (i_local_addr == ADDR_DEBUG_NAME)
            read_word = DEBUG_NAME;
          else if (i_local_addr == ADDR_DEBUG_SYSTICK32)
            read_word = i_systick;
          else if (stat_hit && is_lsw)
            read_word = i_snapshot_lsw[stat_sel];  // Latched by the upper-word read
          else if (stat_hit)
          begin
            read_word            = i_counter_msw[stat_sel];
            o_snapshot[stat_sel] = 1'b1;  // Freeze the matching lower word
          end
        end
        default: ;  // Unmapped blocks read zero
      endcase
    end
  end

  // --------------------------------------------------
  // Result register
  // --------------------------------------------------
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      o_api_read_valid <= 1'b0;
      o_api_read_data  <= '0;
    end
    else
    begin
      o_api_read_valid <= is_read;   // Never for writes or idle
      if (is_read)
        o_api_read_data <= read_word;
    end
  end

endmodule

// File: hdl/nts_engine_regs.sv
/*
 * Top of the NTS engine register file. Host reads come back two cycles
 * after the chip-select cycle; statistics events enter as single pulses.
 */
module nts_engine_regs
  import nts_engine_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_areset,
  input  logic                      i_api_cs,
  input  logic                      i_api_we,
  input  logic [API_ADDR_WIDTH-1:0] i_api_address,
  input  logic [API_DATA_WIDTH-1:0] i_api_write_data,  // No writable registers
  input  logic [NUM_STAT-1:0]       i_stat_events,
  output logic [API_DATA_WIDTH-1:0] o_api_read_data,
  output logic                      o_api_read_valid
);

  // --------------------------------------------------
  // Internal wires
  // --------------------------------------------------
  api_op_e                                 dec_op;
  api_block_e                              dec_block;
  logic [LOCAL_ADDR_WIDTH-1:0]             dec_local_addr;
  logic [NUM_STAT-1:0]                     snapshot;
  logic [NUM_STAT-1:0][API_DATA_WIDTH-1:0] counter_msw;
  logic [NUM_STAT-1:0][API_DATA_WIDTH-1:0] snapshot_lsw;
  logic [API_DATA_WIDTH-1:0]               systick;

  // Request decode
  nts_api_decode nts_api_decode_inst (
    .i_clk         (i_clk),
    .i_areset      (i_areset),
    .i_api_cs      (i_api_cs),
    .i_api_we      (i_api_we),
    .i_api_address (i_api_address),
    .o_op          (dec_op),
    .o_block       (dec_block),
    .o_local_addr  (dec_local_addr)
  );

  // Statistics and tick
  nts_stat_counters nts_stat_counters_inst (
    .i_clk          (i_clk),
    .i_areset       (i_areset),
    .i_stat_events  (i_stat_events),
    .i_snapshot     (snapshot),
    .o_counter_msw  (counter_msw),
    .o_snapshot_lsw (snapshot_lsw),
    .o_systick      (systick)
  );

  // Read mux and result register
  nts_api_readback nts_api_readback_inst (
    .i_clk            (i_clk),
    .i_areset         (i_areset),
    .i_op             (dec_op),
    .i_block          (dec_block),
    .i_local_addr     (dec_local_addr),
    .i_counter_msw    (counter_msw),
    .i_snapshot_lsw   (snapshot_lsw),
    .i_systick        (systick),
    .o_snapshot       (snapshot),
    .o_api_read_data  (o_api_read_data),
    .o_api_read_valid (o_api_read_valid)
  );

endmodule

// File: testbench/tb_clock.sv
/*
 * Clock and reset source for the testbench. 40 ns clock, reset held
 * high for ten rising edges and released on a falling edge.
 */
module tb_clock
(
  output logic o_clk,
  output logic o_areset
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 10;

  initial
  begin
    o_clk = 1'b0;
    forever #20 o_clk = ~o_clk;  // Half of the 40 ns period
  end

  initial
  begin
    o_areset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_areset = 1'b0;
  end

endmodule

// File: testbench/tb_nts_engine_regs.sv
/*
 * Testbench for the NTS engine register file. Drives host reads, writes
 * and event pulses, keeps a counter model and checks every read result.
 */
module tb_nts_engine_regs
  import nts_engine_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES    = 10;
  localparam int BURST_CYCLES    = 200;
  localparam int SNAP_EVENTS     = 5;
  localparam int TICK_GAP        = 37;
  localparam int DRAIN_LIMIT     = 16;
  localparam int TEST_OVERHEAD   = 150;  // Reads, idles and drains of all tests
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + BURST_CYCLES + 2 * SNAP_EVENTS
                                   + TICK_GAP + TEST_OVERHEAD + 200;

  typedef struct packed {
    logic [API_ADDR_WIDTH-1:0] addr;
    logic [API_DATA_WIDTH-1:0] data;
  } exp_read_t;

  logic                        clk;
  logic                        areset;
  logic                        api_cs;
  logic                        api_we;
  logic [API_ADDR_WIDTH-1:0]   api_address;
  logic [API_DATA_WIDTH-1:0]   api_write_data;
  logic [NUM_STAT-1:0]         stat_events;
  logic [API_DATA_WIDTH-1:0]   api_read_data;
  logic                        api_read_valid;
  logic                        host_read;

  exp_read_t                   exp_q[$];
  logic [COUNTER_WIDTH-1:0]    model_count [NUM_STAT];
  logic [LOCAL_ADDR_WIDTH-1:0] stat_addr [NUM_STAT];
  int                          seed;
  int                          cycle_count;
  int                          error_count;
  int                          test_errors_start;
  int                          pass_count;
  int                          fail_count;

  tb_clock tb_clock_inst (
    .o_clk    (clk),
    .o_areset (areset)
  );

  nts_engine_regs nts_engine_regs_inst (
    .i_clk            (clk),
    .i_areset         (areset),
    .i_api_cs         (api_cs),
    .i_api_we         (api_we),
    .i_api_address    (api_address),
    .i_api_write_data (api_write_data),
    .i_stat_events    (stat_events),
    .o_api_read_data  (api_read_data),
    .o_api_read_valid (api_read_valid)
  );

  // Rising edges since reset release
  always_ff @(posedge clk or posedge areset)
  begin
    if (areset)
      cycle_count <= 0;
    else
      cycle_count <= cycle_count + 1;
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  assign host_read = api_cs && !api_we;

  assert property (@(posedge clk) disable iff (areset) $past(host_read, 2) |-> api_read_valid)
  else
  begin
    error_count++;
    $display("%0t: no read result two cycles after a read", $time);
  end

  // Covers writes and idle cycles
  assert property (@(posedge clk) disable iff (areset) !$past(host_read, 2) |-> !api_read_valid)
  else
  begin
    error_count++;
    $display("%0t: read result strobe without a read two cycles earlier", $time);
  end

  // Result compared mid-cycle in issue order
  always @(negedge clk)
  begin
    exp_read_t expected;
    if (!areset && api_read_valid)
    begin
      if (exp_q.size() == 0)
      begin
        error_count++;
        $display("%0t: read result arrived with no read outstanding", $time);
      end
      else
      begin
        expected = exp_q.pop_front();
        assert (api_read_data == expected.data)
        else
        begin
          error_count++;
          $display("mismatch at %0t: address %h expected %h got %h",
                   $time, expected.addr, expected.data, api_read_data);
        end
      end
    end
  end

  // --------------------------------------------------
  // Bus and event tasks entered just after a falling edge
  // --------------------------------------------------
  function automatic logic [API_ADDR_WIDTH-1:0] engine_addr(input logic [7:0] offset);
    return {BLOCK_ENGINE, offset};
  endfunction

  function automatic logic [API_ADDR_WIDTH-1:0] debug_addr(input logic [7:0] offset);
    return {BLOCK_DEBUG, offset};
  endfunction

  task automatic bus_idle(input int cycles);
    api_cs      = 1'b0;
    api_we      = 1'b0;
    stat_events = '0;
    repeat (cycles) @(negedge clk);
  endtask

  task automatic read_expect(input logic [API_ADDR_WIDTH-1:0] addr,
                             input logic [API_DATA_WIDTH-1:0] data);
    exp_read_t entry;
    entry.addr  = addr;
    entry.data  = data;
    api_cs      = 1'b1;
    api_we      = 1'b0;
    api_address = addr;
    exp_q.push_back(entry);
    @(negedge clk);
  endtask

  task automatic write_reg(input logic [API_ADDR_WIDTH-1:0] addr);
    api_cs         = 1'b1;
    api_we         = 1'b1;
    api_address    = addr;
    api_write_data = API_DATA_WIDTH'($random(seed));
    @(negedge clk);
  endtask

  // Decode holds the read one edge later and the tick is 1 + edges seen
  task automatic read_tick();
    read_expect(debug_addr(ADDR_DEBUG_SYSTICK32), API_DATA_WIDTH'(cycle_count + 2));
  endtask

  task automatic read_counter_pair(input int k);
    logic [LOCAL_ADDR_WIDTH-1:0] upper;
    upper = stat_addr[k];
    read_expect(debug_addr(upper), model_count[k][COUNTER_WIDTH-1:API_DATA_WIDTH]);
    read_expect(debug_addr(upper + 8'd1), model_count[k][API_DATA_WIDTH-1:0]);
  endtask

  task automatic event_burst(input int cycles);
    logic [NUM_STAT-1:0] ev;
    api_cs = 1'b0;
    for (int c = 0; c < cycles; c++)
    begin
      ev = NUM_STAT'($random(seed));
      if (($random(seed) & 3) == 0)
        ev = '0;  // Quiet gap
      stat_events = ev;
      for (int i = 0; i < NUM_STAT; i++)
        if (ev[i])
          model_count[i] += 1;
      @(negedge clk);
    end
    stat_events = '0;
  endtask

  task automatic pulse_events(input int k, input int count);
    api_cs = 1'b0;
    api_we = 1'b0;
    for (int n = 0; n < count; n++)
    begin
      stat_events    = '0;
      stat_events[k] = 1'b1;
      model_count[k] += 1;
      @(negedge clk);
    end
    stat_events = '0;
  endtask

  task automatic snapshot_hold(input int k);
    logic [COUNTER_WIDTH-1:0]    held;
    logic [LOCAL_ADDR_WIDTH-1:0] upper;
    held  = model_count[k];
    upper = stat_addr[k];
    read_expect(debug_addr(upper), held[COUNTER_WIDTH-1:API_DATA_WIDTH]);
    pulse_events(k, SNAP_EVENTS);  // First pulse lands on the snapshot edge
    read_expect(debug_addr(upper + 8'd1), held[API_DATA_WIDTH-1:0]);
    bus_idle(2);
    read_counter_pair(k);  // New snapshot shows the new count
  endtask

  task automatic begin_test();
    test_errors_start = error_count;
  endtask

  task automatic finish_test(input string name);
    int wait_cycles;
    wait_cycles = 0;
    bus_idle(0);
    while (exp_q.size() != 0 && wait_cycles < DRAIN_LIMIT)
    begin
      @(negedge clk);
      wait_cycles++;
    end
    if (exp_q.size() != 0)
    begin
      error_count++;
      $display("%0t: %s never returned %0d read results", $time, name, exp_q.size());
      exp_q.delete();
    end
    @(negedge clk);
    if (error_count == test_errors_start)
    begin
      pass_count++;
      $display("test %s: passed", name);
    end
    else
    begin
      fail_count++;
      $display("test %s: failed with %0d errors", name, error_count - test_errors_start);
    end
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial
  begin
    seed           = 32'h914;
    error_count    = 0;
    pass_count     = 0;
    fail_count     = 0;
    api_cs         = 1'b0;
    api_we         = 1'b0;
    api_address    = '0;
    api_write_data = '0;
    stat_events    = '0;
    for (int i = 0; i < NUM_STAT; i++)
      model_count[i] = '0;
    stat_addr[STAT_PROCESSED]  = ADDR_DEBUG_NTS_PROCESSED;
    stat_addr[STAT_BAD_COOKIE] = ADDR_DEBUG_NTS_BAD_COOKIE;
    stat_addr[STAT_BAD_AUTH]   = ADDR_DEBUG_NTS_BAD_AUTH;
    stat_addr[STAT_BAD_KEYID]  = ADDR_DEBUG_NTS_BAD_KEYID;
    stat_addr[STAT_ERR_CRYPTO] = ADDR_DEBUG_ERROR_CRYPTO;
    stat_addr[STAT_ERR_TXBUF]  = ADDR_DEBUG_ERROR_TXBUF;

    @(negedge areset);  // Released on a falling edge
    bus_idle(2);

    begin_test();
    read_expect(engine_addr(8'h00), "NTS_");
    read_expect(engine_addr(8'h01), "ENGN");
    read_expect(engine_addr(8'h02), "0.01");
    read_expect(engine_addr(8'h08), 32'd1);
    read_expect(debug_addr(8'h08), "DBUG");
    read_expect(engine_addr(8'h03), '0);
    read_expect(engine_addr(8'hff), '0);
    read_expect(debug_addr(8'h0a), '0);
    read_expect(debug_addr(8'h24), '0);
    read_expect(debug_addr(8'hfe), '0);
    read_expect(12'h200, '0);
    read_expect(12'h308, '0);
    read_expect(12'hf00, '0);
    finish_test("identity");

    begin_test();
    event_burst(BURST_CYCLES);
    bus_idle(2);
    for (int k = 0; k < NUM_STAT; k++)
      read_counter_pair(k);
    finish_test("counting");

    begin_test();
    snapshot_hold(STAT_BAD_AUTH);
    bus_idle(1);
    snapshot_hold(STAT_ERR_TXBUF);
    finish_test("snapshot hold");

    // Expected values differ by the gap in cycles
    begin_test();
    read_tick();
    bus_idle(TICK_GAP - 1);
    read_tick();
    read_tick();
    finish_test("tick");

    begin_test();
    write_reg(engine_addr(8'h00));
    write_reg(engine_addr(8'h08));
    write_reg(debug_addr(ADDR_DEBUG_NAME));
    write_reg(debug_addr(ADDR_DEBUG_SYSTICK32));
    for (int k = 0; k < NUM_STAT; k++)
    begin
      write_reg(debug_addr(stat_addr[k]));
      write_reg(debug_addr(stat_addr[k] + 8'd1));
    end
    bus_idle(3);
    read_expect(engine_addr(8'h00), "NTS_");
    write_reg(engine_addr(8'h01));  // Gap in the read stream
    read_expect(engine_addr(8'h01), "ENGN");
    read_expect(engine_addr(8'h02), "0.01");
    read_expect(engine_addr(8'h08), 32'd1);
    read_expect(debug_addr(8'h08), "DBUG");
    read_tick();
    for (int k = 0; k < NUM_STAT; k++)
      read_counter_pair(k);
    finish_test("writes and back-to-back reads");

    $display("tests passed: %0d, tests failed: %0d, errors: %0d",
             pass_count, fail_count, error_count);
    if (fail_count == 0 && error_count == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("** FAIL **");
    $finish;
  end

endmodule

// File: nts_engine_regs.f
hdl/nts_engine_pkg.sv
hdl/nts_api_decode.sv
hdl/nts_stat_counters.sv
hdl/nts_api_readback.sv
hdl/nts_engine_regs.sv
testbench/tb_clock.sv
testbench/tb_nts_engine_regs.sv

// File: Makefile
# Verilator build and run of the NTS engine register file testbench.
# Every variable below can be overridden on the command line.

VERILATOR   ?= verilator
TOP         ?= tb_nts_engine_regs
FILELIST    ?= nts_engine_regs.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
VFLAGS      ?= --binary --timing --assert -Wno-fatal
EXTRA_FLAGS ?=

SIM_BIN := $(BUILD_DIR)/V$(TOP)
PASS_TEXT := ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS EXTRA_FLAGS"

# The run counts as passed only when the log holds the pass line
test:
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	$(SIM_BIN) | tee $(LOG)
	@if grep -qF -- '$(PASS_TEXT)' $(LOG); then \
		echo "result: simulation passed"; \
	else \
		echo "result: simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
